/* isaPkg.sv */
package isaPkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] opR      = 7'b0110011;
    localparam logic [6:0] opImm    = 7'b0010011;
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;

    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    localparam logic [2:0] f3Word   = 3'b010; // lw / sw width
    localparam logic [2:0] f3Beq    = 3'b000;

    localparam logic f7Sub = 1'b1; // funct7[5] set for sub

    // One instruction word, seen through each format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;  // imm[11:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;  // imm[4:0]
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] immHi;  // imm[10:5]
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] immLo;  // imm[4:1]
            logic       imm11;
            logic [6:0] opcode;
        } bType;
    } instWord;

endpackage

/* ctrlPkg.sv */
package ctrlPkg;

    localparam int unsigned xlen = 32;

    // Memory sizes in words
    localparam int unsigned instDepth    = 64;
    localparam int unsigned dataDepth    = 64;
    localparam int unsigned instAddrBits = $clog2(instDepth);
    localparam int unsigned dataAddrBits = $clog2(dataDepth);

    localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

    // ALU operation code
    typedef logic [3:0] aluOp;

    localparam aluOp aluAnd = 4'b0000;
    localparam aluOp aluOr  = 4'b0001;
    localparam aluOp aluAdd = 4'b0010;
    localparam aluOp aluSub = 4'b0110;
    localparam aluOp aluSlt = 4'b0111;

    // Second ALU operand
    localparam logic srcReg = 1'b0;
    localparam logic srcImm = 1'b1;

    // Writeback source
    localparam logic wbAlu = 1'b0;
    localparam logic wbMem = 1'b1;

endpackage

/* programCounter.sv */
module programCounter (
    input  logic                     CLK,
    input  logic                     reset,
    input  logic                     branch,
    input  logic                     zero,
    input  logic [ctrlPkg::xlen-1:0] imm,
    output logic [ctrlPkg::xlen-1:0] pc
);
    import ctrlPkg::*;

    logic            taken;
    logic [xlen-1:0] nextPc;

    // beq taken when operands compare equal
    assign taken  = branch & zero;
    assign nextPc = taken ? pc + imm : pc + 32'd4; // B-immediate is already even

    always_ff @(posedge CLK) begin
        if (reset) begin
            pc <= resetPc;
        end else begin
            pc <= nextPc;
        end
    end

endmodule

/* instMem.sv */
module instMem (
    input  logic [ctrlPkg::xlen-1:0] pc,
    output logic [31:0]              inst
);
    import ctrlPkg::*;

    logic [31:0] rom [instDepth];

    initial begin
        for (int i = 0; i < instDepth; i++) begin
            rom[i] = 32'h0000_0000; // Words past the program read as zero
        end
        $readmemh("program.hex", rom);
    end

    assign inst = rom[pc[instAddrBits+1:2]];

endmodule

/* regFile.sv */
module regFile (
    input  logic        CLK,
    input  logic        reset,
    input  logic [4:0]  rs1,
    input  logic [4:0]  rs2,
    input  logic [4:0]  rd,
    input  logic [31:0] wd,
    input  logic        we,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);

    logic [31:0] regs [32];

    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'h0;
            end
        end else if (we && rd != 5'd0) begin // x0 never written
            regs[rd] <= wd;
        end
    end

    // Reads see the old value during a write cycle
    assign rd1 = regs[rs1];
    assign rd2 = regs[rs2];

endmodule

/* immGen.sv */
module immGen (
    input  isaPkg::instWord inst,
    output logic [31:0]     imm
);
    import isaPkg::*;

    always_comb begin
        case (inst.rType.opcode)
            opImm, opLoad: begin
                imm = {{20{inst.iType.imm[11]}}, inst.iType.imm};
            end
            opStore: begin
                imm = {{20{inst.sType.immHi[6]}}, inst.sType.immHi, inst.sType.immLo};
            end
            opBranch: begin
                // Byte offset, bit 0 always clear
                imm = {{19{inst.bType.imm12}}, inst.bType.imm12, inst.bType.imm11,
                       inst.bType.immHi, inst.bType.immLo, 1'b0};
            end
            default: begin
                imm = 32'h0;
            end
        endcase
    end

endmodule

/* control.sv */
module control (
    input  logic            reset,
    input  isaPkg::instWord inst,
    output logic            aluSrc,
    output ctrlPkg::aluOp   aluCtl,
    output logic            memWrite,
    output logic            memToReg,
    output logic            regWrite,
    output logic            branch
);
    import isaPkg::*;
    import ctrlPkg::*;

    always_comb begin
        // Safe defaults, no state changes
        aluSrc   = srcReg;
        aluCtl   = aluAdd;
        memWrite = 1'b0;
        memToReg = wbAlu;
        regWrite = 1'b0;
        branch   = 1'b0;

        if (!reset) begin
            case (inst.rType.opcode)
                opR: begin
                    regWrite = 1'b1;
                    case (inst.rType.funct3)
                        f3AddSub: aluCtl = (inst.rType.funct7[5] == f7Sub) ? aluSub : aluAdd;
                        f3Slt:    aluCtl = aluSlt;
                        f3Or:     aluCtl = aluOr;
                        f3And:    aluCtl = aluAnd;
                        default:  regWrite = 1'b0; // Unsupported R op
                    endcase
                end
                opImm: begin
                    if (inst.iType.funct3 == f3AddSub) begin // addi only
                        aluSrc   = srcImm;
                        regWrite = 1'b1;
                    end
                end
                opLoad: begin
                    if (inst.iType.funct3 == f3Word) begin
                        aluSrc   = srcImm;
                        memToReg = wbMem;
                        regWrite = 1'b1;
                    end
                end
                opStore: begin
                    if (inst.sType.funct3 == f3Word) begin
                        aluSrc   = srcImm;
                        memWrite = 1'b1;
                    end
                end
                opBranch: begin
                    if (inst.bType.funct3 == f3Beq) begin
                        aluCtl = aluSub; // Equal when difference is zero
                        branch = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    end

endmodule

/* alu.sv */
module alu (
    input  logic [ctrlPkg::xlen-1:0] a,
    input  logic [ctrlPkg::xlen-1:0] b,
    input  ctrlPkg::aluOp            op,
    output logic [ctrlPkg::xlen-1:0] result,
    output logic                     zero
);
    import ctrlPkg::*;

    always_comb begin
        case (op)
            aluAdd: result = a + b;
            aluSub: result = a - b;
            aluAnd: result = a & b;
            aluOr:  result = a | b;
            aluSlt: begin
                // Signed compare
                result = {{(xlen-1){1'b0}}, ($signed(a) < $signed(b))};
            end
            default: result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

/* dataMem.sv */
module dataMem (
    input  logic                     CLK,
    input  logic [ctrlPkg::xlen-1:0] addr,
    input  logic [ctrlPkg::xlen-1:0] wd,
    input  logic                     we,
    output logic [ctrlPkg::xlen-1:0] rd
);
    import ctrlPkg::*;

    logic [xlen-1:0]         mem [dataDepth];
    logic [dataAddrBits-1:0] wordAddr;

    assign wordAddr = addr[dataAddrBits+1:2]; // Word aligned accesses only

    always_ff @(posedge CLK) begin
        if (we) begin
            mem[wordAddr] <= wd;
        end
    end

    assign rd = mem[wordAddr];

endmodule

/* singleCpu.sv */
module singleCpu (
    input  logic                     CLK,
    input  logic                     reset,
    output logic [ctrlPkg::xlen-1:0] pc,
    output logic [31:0]              inst,
    output logic                     wbEn,
    output logic [4:0]               wbAddr,
    output logic [ctrlPkg::xlen-1:0] wbData
);
    import isaPkg::*;
    import ctrlPkg::*;

    instWord         fetched;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rd1;
    logic [xlen-1:0] rd2;
    logic [xlen-1:0] aluB;
    logic [xlen-1:0] aluResult;
    logic [xlen-1:0] readData;
    logic            zero;
    logic            aluSrc;
    aluOp            aluCtl;
    logic            memWrite;
    logic            memToReg;
    logic            regWrite;
    logic            branch;

    assign fetched = inst;

    programCounter pc0 (.CLK(CLK), .reset(reset), .branch(branch), .zero(zero),
                        .imm(imm), .pc(pc));

    instMem imem0 (.pc(pc), .inst(inst));

    regFile rf0 (.CLK(CLK), .reset(reset), .rs1(fetched.rType.rs1), .rs2(fetched.rType.rs2),
                 .rd(fetched.rType.rd), .wd(wbData), .we(regWrite), .rd1(rd1), .rd2(rd2));

    immGen imm0 (.inst(fetched), .imm(imm));

    control ctl0 (.reset(reset), .inst(fetched), .aluSrc(aluSrc), .aluCtl(aluCtl),
                  .memWrite(memWrite), .memToReg(memToReg), .regWrite(regWrite),
                  .branch(branch));

    assign aluB = (aluSrc == srcImm) ? imm : rd2;

    alu alu0 (.a(rd1), .b(aluB), .op(aluCtl), .result(aluResult), .zero(zero));

    dataMem dmem0 (.CLK(CLK), .addr(aluResult), .wd(rd2), .we(memWrite), .rd(readData));

    assign wbData = (memToReg == wbMem) ? readData : aluResult; // Load or ALU result
    assign wbEn   = regWrite;
    assign wbAddr = fetched.rType.rd;

endmodule

/* singleCpuTb.sv */
module singleCpuTb;
    timeunit 1ns;
    timeprecision 100ps;

    // Expected state of one executing instruction
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        wbEn;
        logic [4:0]  wbAddr;
        logic [31:0] wbData;
    } rowType;

    localparam int numRows     = 16;
    localparam int resetCycles = 2;
    localparam int cycleLimit  = numRows + resetCycles + 10;

    // One row per cycle after reset
    // Address and data only checked when wbEn is set
    localparam rowType expRows [numRows] = '{
        '{32'd0,  32'h0050_0093, 1'b1, 5'd1,  32'd5},          // addi x1, x0, 5
        '{32'd4,  32'hFFD0_0113, 1'b1, 5'd2,  32'hFFFF_FFFD},  // addi x2, x0, -3
        '{32'd8,  32'h0020_81B3, 1'b1, 5'd3,  32'd2},          // add x3, x1, x2
        '{32'd12, 32'h4020_8233, 1'b1, 5'd4,  32'd8},          // sub x4, x1, x2
        '{32'd16, 32'h0020_F2B3, 1'b1, 5'd5,  32'd5},          // and x5, x1, x2
        '{32'd20, 32'h0020_E333, 1'b1, 5'd6,  32'hFFFF_FFFD},  // or x6, x1, x2
        '{32'd24, 32'h0011_23B3, 1'b1, 5'd7,  32'd1},          // slt x7, x2, x1
        '{32'd28, 32'h0030_2423, 1'b0, 5'd0,  32'd0},          // sw x3, 8(x0)
        '{32'd32, 32'h0080_2403, 1'b1, 5'd8,  32'd2},          // lw x8, 8(x0)
        '{32'd36, 32'h0020_8463, 1'b0, 5'd0,  32'd0},          // beq x1, x2 not taken
        '{32'd40, 32'h0031_8463, 1'b0, 5'd0,  32'd0},          // beq x3, x3 taken
        '{32'd48, 32'h0070_0513, 1'b1, 5'd10, 32'd7},          // addi x10, x0, 7
        '{32'd52, 32'h0000_0063, 1'b0, 5'd0,  32'd0},          // Halt loop
        '{32'd52, 32'h0000_0063, 1'b0, 5'd0,  32'd0},
        '{32'd52, 32'h0000_0063, 1'b0, 5'd0,  32'd0},
        '{32'd52, 32'h0000_0063, 1'b0, 5'd0,  32'd0}
    };

    logic        CLK;
    logic        reset;
    logic [31:0] pc;
    logic [31:0] inst;
    logic        wbEn;
    logic [4:0]  wbAddr;
    logic [31:0] wbData;
    int          cycleCount = 0;

    singleCpu dut0 (.CLK(CLK), .reset(reset), .pc(pc), .inst(inst), .wbEn(wbEn),
                    .wbAddr(wbAddr), .wbData(wbData));

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // Run length guard
    always @(posedge CLK) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("Timeout: the test did not finish within %0d clock cycles", cycleLimit);
            $display("** FAIL **");
            $fatal(1, "Simulation timed out");
        end
    end

    task automatic compareValue(input logic [31:0] actual, input logic [31:0] expected,
                                input string what);
        if (actual !== expected) begin
            $display("Fail at time %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("** FAIL **");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic verifyCycle(input int idx);
        rowType exp;
        exp = expRows[idx];
        compareValue(pc, exp.pc, $sformatf("pc in row %0d", idx));
        compareValue(inst, exp.inst, $sformatf("inst in row %0d", idx));
        compareValue({31'd0, wbEn}, {31'd0, exp.wbEn}, $sformatf("wbEn in row %0d", idx));
        if (exp.wbEn) begin
            compareValue({27'd0, wbAddr}, {27'd0, exp.wbAddr},
                         $sformatf("wbAddr in row %0d", idx));
            compareValue(wbData, exp.wbData, $sformatf("wbData in row %0d", idx));
        end
    endtask

    initial begin
        reset = 1'b1;
        @(posedge CLK);
        #9;
        compareValue(pc, 32'd0, "pc during reset");
        compareValue({31'd0, wbEn}, 32'd0, "wbEn during reset");
        @(posedge CLK);
        #1 reset = 1'b0; // First instruction runs from here
        for (int i = 0; i < numRows; i++) begin
            #8; // Just before the next rising edge
            verifyCycle(i);
            @(posedge CLK);
            #1;
        end
        $display("** PASS **");
        $finish;
    end

endmodule

/* flist.f */
isaPkg.sv
ctrlPkg.sv
programCounter.sv
instMem.sv
regFile.sv
immGen.sv
control.sv
alu.sv
dataMem.sv
singleCpu.sv
singleCpuTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= singleCpuTb
FLIST     ?= flist.f
BUILD     ?= obj_dir
PASSMSG   ?= ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --top-module $(TOP) -Mdir $(BUILD) -f $(FLIST)

run: build
	@out=$$(./$(BUILD)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASSMSG)'

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD)

/* program.hex */
// One instruction word per line in hex, starting at byte address 0
// Trailing text on each line names the instruction
00500093 // addi x1, x0, 5
FFD00113 // addi x2, x0, -3
002081B3 // add  x3, x1, x2
40208233 // sub  x4, x1, x2
0020F2B3 // and  x5, x1, x2
0020E333 // or   x6, x1, x2
001123B3 // slt  x7, x2, x1
00302423 // sw   x3, 8(x0)
00802403 // lw   x8, 8(x0)
00208463 // beq  x1, x2, +8
00318463 // beq  x3, x3, +8
00100493 // addi x9, x0, 1
00700513 // addi x10, x0, 7
00000063 // beq  x0, x0, 0
